// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = alu_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/alu_execute.sv ====
`timescale 1ns/1ns

module alu_execute #(
        parameter int data_width = 32
) (
        input  logic                           clk,
        input  logic                           rst_n,
        input  logic                           req_valid,      // one request per cycle max
        input  alu_pkg::alu_op_e               req_op,
        input  logic [data_width-1:0]          req_src1,
        input  logic [data_width-1:0]          req_src2,
        output logic                           push,           // result register holds a new entry
        output logic [data_width-1:0]          push_result,
        output logic [alu_pkg::flag_count-1:0] push_flags      // {overflow, cout, zero}
);

        typedef enum logic [1:0] {
                sel_and,                        // a & b per bit
                sel_or,                         // a | b per bit
                sel_sum,                        // full adder sum
                sel_less                        // slt bit into bit 0
        } sel_e;

        logic                  a_invert;        // flip src1 before the slices
        logic                  b_invert;        // flip src2 before the slices
        logic                  carry_in;        // +1 for sub and slt
        sel_e                  sel;
        logic                  op_known;        // opcode decoded to a real op
        logic                  arith_op;        // add, sub, slt drive cout
        logic                  ovf_op;          // add, sub drive overflow
        logic [data_width:0]   carry;           // ripple chain, carry[0] is carry in
        logic [data_width-1:0] sum;
        logic [data_width-1:0] slice_result;
        logic                  ovf_raw;         // signed overflow of the adder
        logic                  set_bit;         // true signed a < b
        logic [data_width-1:0] result_q;
        logic                  cout_q;
        logic                  ovf_q;

        ////////////////////////////////////////
        // opcode decode
        ////////////////////////////////////////

        always_comb begin
                a_invert = 1'b0;
                b_invert = 1'b0;
                carry_in = 1'b0;
                sel      = sel_and;
                op_known = 1'b1;
                arith_op = 1'b0;
                ovf_op   = 1'b0;
                case (req_op)
                        alu_pkg::op_and: sel = sel_and;
                        alu_pkg::op_or:  sel = sel_or;
                        alu_pkg::op_add: begin
                                sel      = sel_sum;
                                arith_op = 1'b1;
                                ovf_op   = 1'b1;
                        end
                        alu_pkg::op_sub: begin
                                b_invert = 1'b1;        // a + ~b + 1
                                carry_in = 1'b1;
                                sel      = sel_sum;
                                arith_op = 1'b1;
                                ovf_op   = 1'b1;
                        end
                        alu_pkg::op_slt: begin
                                b_invert = 1'b1;        // same subtract, only the sign is kept
                                carry_in = 1'b1;
                                sel      = sel_less;
                                arith_op = 1'b1;
                        end
                        alu_pkg::op_nor: begin
                                a_invert = 1'b1;        // ~a & ~b
                                b_invert = 1'b1;
                                sel      = sel_and;
                        end
                        default: op_known = 1'b0;       // result forced to 0 below
                endcase
        end

        ////////////////////////////////////////
        // ripple carry slices
        ////////////////////////////////////////

        assign carry[0] = carry_in;
        assign ovf_raw  = carry[data_width] ^ carry[data_width-1];     // carry into vs out of msb
        assign set_bit  = sum[data_width-1] ^ ovf_raw;  // sign corrected for overflow

        for (genvar i = 0; i < data_width; i++) begin : g_slice
                logic a_bit;
                logic b_bit;
                logic less_bit;

                assign a_bit        = req_src1[i] ^ a_invert;
                assign b_bit        = req_src2[i] ^ b_invert;
                assign less_bit     = (i == 0) ? set_bit : 1'b0;  // slt is zero extended
                assign sum[i]       = a_bit ^ b_bit ^ carry[i];
                assign carry[i+1]   = (a_bit & b_bit) | (carry[i] & (a_bit ^ b_bit));
                assign slice_result[i] = (sel == sel_and) ? (a_bit & b_bit) :
                                         (sel == sel_or)  ? (a_bit | b_bit) :
                                         (sel == sel_sum) ? sum[i] : less_bit;
        end

        ////////////////////////////////////////
        // result register
        ////////////////////////////////////////

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        push <= 1'b0;
                end else begin
                        push <= req_valid;      // fixed one cycle latency
                end
        end

        always_ff @(posedge clk) begin
                if (req_valid) begin
                        result_q <= op_known ? slice_result : '0;
                        cout_q   <= arith_op & carry[data_width];
                        ovf_q    <= ovf_op & ovf_raw;
                end
        end

        assign push_result = result_q;
        assign push_flags  = {ovf_q, cout_q, ~|result_q};     // zero from the registered word

endmodule

// ==== hdl/alu_output_stage.sv ====
`timescale 1ns/1ns

module alu_output_stage #(
        parameter int data_width   = 32,
        parameter int credit_width = 4
) (
        input  logic                           clk,
        input  logic                           rst_n,
        input  logic                           out_credit,     // sink grants one more result
        input  logic                           empty,
        input  logic [data_width-1:0]          head_result,
        input  logic [alu_pkg::flag_count-1:0] head_flags,     // {overflow, cout, zero}
        output logic                           pop,
        output logic                           out_valid,
        output logic [data_width-1:0]          out_result,
        output logic                           out_zero,
        output logic                           out_cout,
        output logic                           out_overflow
);

        logic [credit_width-1:0] credit_cnt;    // sink credits not yet spent

        ////////////////////////////////////////
        // sink credits and pop decision
        ////////////////////////////////////////

        assign pop = !empty && (credit_cnt != '0);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        credit_cnt <= '0;
                end else begin
                        case ({out_credit, pop})
                                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                                default: credit_cnt <= credit_cnt;     // grant and spend cancel
                        endcase
                end
        end

        ////////////////////////////////////////
        // output registers
        ////////////////////////////////////////

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= pop;       // one cycle per result
                end
        end

        always_ff @(posedge clk) begin
                if (pop) begin
                        out_result   <= head_result;
                        out_zero     <= head_flags[0];
                        out_cout     <= head_flags[1];
                        out_overflow <= head_flags[2];
                end
        end

endmodule

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

        ////////////////////////////////////////
        // opcode encoding
        ////////////////////////////////////////

        localparam int op_width = 4;            // opcode bits on req_op

        // bit 3 inverts a, bit 2 inverts b
        typedef enum logic [op_width-1:0] {
                op_and = 4'b0000,               // bitwise and
                op_or  = 4'b0001,               // bitwise or
                op_add = 4'b0010,               // two's complement add
                op_sub = 4'b0110,               // src1 - src2
                op_slt = 4'b0111,               // signed set on less than
                op_nor = 4'b1100                // ~(src1 | src2)
        } alu_op_e;

        ////////////////////////////////////////
        // flags carried with every result
        ////////////////////////////////////////

        // packed as {overflow, cout, zero}, zero in bit 0
        localparam int flag_count = 3;

endpackage

// ==== hdl/alu_result_fifo.sv ====
`timescale 1ns/1ns

module alu_result_fifo #(
        parameter int data_width = 32,
        parameter int fifo_depth = 4
) (
        input  logic                           clk,
        input  logic                           rst_n,
        input  logic                           push,           // write at this edge
        input  logic [data_width-1:0]          push_result,
        input  logic [alu_pkg::flag_count-1:0] push_flags,
        input  logic                           pop,            // head leaves at this edge
        output logic                           empty,
        output logic [data_width-1:0]          head_result,
        output logic [alu_pkg::flag_count-1:0] head_flags,
        output logic                           in_credit       // one source credit back per pop
);

        localparam int ptr_width   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
        localparam int count_width = $clog2(fifo_depth + 1);

        logic [data_width-1:0]          mem_result [fifo_depth];
        logic [alu_pkg::flag_count-1:0] mem_flags  [fifo_depth];
        logic [ptr_width-1:0]           wr_ptr;
        logic [ptr_width-1:0]           rd_ptr;
        logic [count_width-1:0]         count;          // entries held, never above fifo_depth

        ////////////////////////////////////////
        // storage
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (push) begin
                        mem_result[wr_ptr] <= push_result;
                        mem_flags[wr_ptr]  <= push_flags;
                end
        end

        assign head_result = mem_result[rd_ptr];
        assign head_flags  = mem_flags[rd_ptr];
        assign empty       = (count == '0);

        ////////////////////////////////////////
        // pointers, occupancy, credit return
        ////////////////////////////////////////

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr    <= '0;
                        rd_ptr    <= '0;
                        count     <= '0;
                        in_credit <= 1'b0;
                end else begin
                        if (push) begin
                                // wrap by compare, depth need not be a power of two
                                wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;        // both or neither
                        endcase
                        in_credit <= pop;       // pulse follows the departing entry
                end
        end

endmodule

// ==== hdl/alu_top.sv ====
`timescale 1ns/1ns

module alu_top #(
        parameter int data_width   = 32,
        parameter int fifo_depth   = 4,        // also the source's starting credits
        parameter int credit_width = 4
) (
        input  logic                  clk,
        input  logic                  rst_n,
        // source side
        input  logic                  req_valid,
        input  alu_pkg::alu_op_e      req_op,
        input  logic [data_width-1:0] req_src1,
        input  logic [data_width-1:0] req_src2,
        output logic                  in_credit,
        // sink side
        output logic                  out_valid,
        output logic [data_width-1:0] out_result,
        output logic                  out_zero,
        output logic                  out_cout,
        output logic                  out_overflow,
        input  logic                  out_credit
);

        logic                           push;           // execute -> fifo
        logic [data_width-1:0]          push_result;
        logic [alu_pkg::flag_count-1:0] push_flags;
        logic                           pop;            // output stage -> fifo
        logic                           empty;
        logic [data_width-1:0]          head_result;
        logic [alu_pkg::flag_count-1:0] head_flags;

        ////////////////////////////////////////
        // execute, buffer, output
        ////////////////////////////////////////

        alu_execute #(
                .data_width (data_width)
        ) u_execute (
                .clk         (clk),
                .rst_n       (rst_n),
                .req_valid   (req_valid),
                .req_op      (req_op),
                .req_src1    (req_src1),
                .req_src2    (req_src2),
                .push        (push),
                .push_result (push_result),
                .push_flags  (push_flags)
        );

        alu_result_fifo #(
                .data_width (data_width),
                .fifo_depth (fifo_depth)
        ) u_fifo (
                .clk         (clk),
                .rst_n       (rst_n),
                .push        (push),
                .push_result (push_result),
                .push_flags  (push_flags),
                .pop         (pop),
                .empty       (empty),
                .head_result (head_result),
                .head_flags  (head_flags),
                .in_credit   (in_credit)
        );

        alu_output_stage #(
                .data_width   (data_width),
                .credit_width (credit_width)
        ) u_output (
                .clk          (clk),
                .rst_n        (rst_n),
                .out_credit   (out_credit),
                .empty        (empty),
                .head_result  (head_result),
                .head_flags   (head_flags),
                .pop          (pop),
                .out_valid    (out_valid),
                .out_result   (out_result),
                .out_zero     (out_zero),
                .out_cout     (out_cout),
                .out_overflow (out_overflow)
        );

endmodule

// ==== testbench/alu_assertions.sv ====
`timescale 1ns/1ns

module alu_assertions #(
        parameter int fifo_depth = 4
) (
        input logic clk,
        input logic rst_n,
        input logic req_valid,          // request accepted by execute
        input logic push,               // execute -> buffer
        input logic pop,                // buffer -> output stage
        input logic in_credit,          // credit back to source
        input logic out_valid,
        input logic out_credit          // credit from sink
);

        logic [31:0] accepted_cnt;      // requests taken so far
        logic [31:0] returned_cnt;      // in_credit pulses so far
        logic [31:0] granted_cnt;       // out_credit pulses so far
        logic [31:0] shown_cnt;         // out_valid cycles so far
        logic [31:0] occupancy;         // shadow of buffer fill
        int          fail_count = 0;    // property failures so far

        ////////////////////////////////////////
        // shadow counters
        ////////////////////////////////////////

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        accepted_cnt <= '0;
                        returned_cnt <= '0;
                        granted_cnt  <= '0;
                        shown_cnt    <= '0;
                        occupancy    <= '0;
                end else begin
                        accepted_cnt <= accepted_cnt + 32'(req_valid);
                        returned_cnt <= returned_cnt + 32'(in_credit);
                        granted_cnt  <= granted_cnt + 32'(out_credit);
                        shown_cnt    <= shown_cnt + 32'(out_valid);
                        occupancy    <= occupancy + 32'(push) - 32'(pop);   // both cancel
                end
        end

        ////////////////////////////////////////
        // properties
        ////////////////////////////////////////

        a_quiet_in_reset: assert property (@(posedge clk)
                !rst_n |-> !out_valid && !in_credit)
                else begin
                        $error("out_valid or in_credit high during reset");
                        fail_count++;
                end

        a_quiet_after_reset: assert property (@(posedge clk)
                $rose(rst_n) |-> !out_valid && !in_credit)
                else begin
                        $error("out_valid or in_credit high right after reset");
                        fail_count++;
                end

        // each result shown must be covered by a credit granted earlier
        a_sink_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid |-> shown_cnt < granted_cnt)
                else begin
                        $error("out_valid without a sink credit held");
                        fail_count++;
                end

        a_credit_return: assert property (@(posedge clk) disable iff (!rst_n)
                in_credit |-> returned_cnt < accepted_cnt)
                else begin
                        $error("more credits returned than requests accepted");
                        fail_count++;
                end

        a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
                occupancy <= 32'(fifo_depth))
                else begin
                        $error("buffer holds more than fifo_depth entries");
                        fail_count++;
                end

endmodule

// ==== testbench/alu_tb.sv ====
`timescale 1ns/1ns

module alu_tb;

        localparam int data_width     = 32;
        localparam int fifo_depth     = 4;
        localparam int credit_width   = 4;
        localparam int req_count      = 400;
        localparam int timeout_cycles = (req_count * 20) + 200;
        localparam int sink_limit     = 8;     // keeps credit_cnt well below wrap

        logic                  clk = 1'b0;
        logic                  rst_n;
        logic                  req_valid;
        alu_pkg::alu_op_e      req_op;
        logic [data_width-1:0] req_src1;
        logic [data_width-1:0] req_src2;
        logic                  in_credit;
        logic                  out_valid;
        logic [data_width-1:0] out_result;
        logic                  out_zero;
        logic                  out_cout;
        logic                  out_overflow;
        logic                  out_credit;

        logic [data_width-1:0]          exp_result_q [$];   // in request order
        logic [alu_pkg::flag_count-1:0] exp_flag_q [$];     // {overflow, cout, zero}
        logic [31:0] lcg_state = 32'd67095;
        int          errors      = 0;
        int          issued      = 0;
        int          delivered   = 0;
        int          src_credits = fifo_depth;              // source side counter
        int          granted     = 0;
        int          sink_run    = 0;                       // cycles left in burst or gap
        logic        sink_on     = 1'b0;
        int          cycle_count = 0;

        always #50 clk = ~clk;                  // 100 ns period

        alu_top #(
                .data_width   (data_width),
                .fifo_depth   (fifo_depth),
                .credit_width (credit_width)
        ) u_alu_top (
                .clk          (clk),
                .rst_n        (rst_n),
                .req_valid    (req_valid),
                .req_op       (req_op),
                .req_src1     (req_src1),
                .req_src2     (req_src2),
                .in_credit    (in_credit),
                .out_valid    (out_valid),
                .out_result   (out_result),
                .out_zero     (out_zero),
                .out_cout     (out_cout),
                .out_overflow (out_overflow),
                .out_credit   (out_credit)
        );

        bind alu_top alu_assertions #(
                .fifo_depth (fifo_depth)
        ) u_checks (
                .clk        (clk),
                .rst_n      (rst_n),
                .req_valid  (req_valid),
                .push       (push),
                .pop        (pop),
                .in_credit  (in_credit),
                .out_valid  (out_valid),
                .out_credit (out_credit)
        );

        ////////////////////////////////////////
        // random stimulus
        ////////////////////////////////////////

        function automatic logic [31:0] next_rand();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state;
        endfunction

        function automatic logic [data_width-1:0] pick_operand();
                logic [31:0] r;
                r = next_rand();
                case (r[31:29])                 // edge values most of the time
                        3'd0:    return '1;
                        3'd1:    return {1'b1, {(data_width-1){1'b0}}};
                        3'd2:    return '0;
                        3'd3:    return {1'b0, {(data_width-1){1'b1}}};
                        3'd4:    return data_width'(1);
                        default: return data_width'(next_rand());
                endcase
        endfunction

        function automatic alu_pkg::alu_op_e pick_opcode();
                logic [31:0] r;
                r = next_rand();
                case (r[31:29])
                        3'd0:       return alu_pkg::op_and;
                        3'd1:       return alu_pkg::op_or;
                        3'd2:       return alu_pkg::op_nor;
                        3'd3:       return alu_pkg::op_add;
                        3'd4, 3'd6: return alu_pkg::op_sub;
                        default:    return alu_pkg::op_slt;
                endcase
        endfunction

        ////////////////////////////////////////
        // reference model
        ////////////////////////////////////////

        function automatic void compute_expected(
                input  alu_pkg::alu_op_e               op,
                input  logic [data_width-1:0]          a,
                input  logic [data_width-1:0]          b,
                output logic [data_width-1:0]          res,
                output logic [alu_pkg::flag_count-1:0] flags
        );
                logic [data_width:0] wide;      // carry in the top bit
                logic                cout;
                logic                ovf;
                cout = 1'b0;
                ovf  = 1'b0;
                case (op)
                        alu_pkg::op_and: res = a & b;
                        alu_pkg::op_or:  res = a | b;
                        alu_pkg::op_nor: res = ~(a | b);
                        alu_pkg::op_add: begin
                                wide = {1'b0, a} + {1'b0, b};
                                res  = wide[data_width-1:0];
                                cout = wide[data_width];
                                ovf  = (a[data_width-1] == b[data_width-1]) &&
                                       (res[data_width-1] != a[data_width-1]);
                        end
                        alu_pkg::op_sub: begin
                                wide = {1'b0, a} + {1'b0, ~b} + (data_width+1)'(1);
                                res  = wide[data_width-1:0];
                                cout = wide[data_width];
                                ovf  = (a[data_width-1] != b[data_width-1]) &&
                                       (res[data_width-1] != a[data_width-1]);
                        end
                        alu_pkg::op_slt: begin
                                wide = {1'b0, a} + {1'b0, ~b} + (data_width+1)'(1);
                                cout = wide[data_width];        // carry of the subtract
                                res  = ($signed(a) < $signed(b)) ? data_width'(1) : '0;
                        end
                        default: res = '0;
                endcase
                flags = {ovf, cout, (res == '0)};
        endfunction

        ////////////////////////////////////////
        // source and sink models
        ////////////////////////////////////////

        task automatic issue_request();
                alu_pkg::alu_op_e               op;
                logic [data_width-1:0]          a;
                logic [data_width-1:0]          b;
                logic [data_width-1:0]          res;
                logic [alu_pkg::flag_count-1:0] flags;
                op = pick_opcode();
                a  = pick_operand();
                b  = pick_operand();
                compute_expected(op, a, b, res, flags);
                exp_result_q.push_back(res);
                exp_flag_q.push_back(flags);
                req_valid   = 1'b1;
                req_op      = op;
                req_src1    = a;
                req_src2    = b;
                src_credits = src_credits - 1;  // one credit per request
                issued      = issued + 1;
        endtask

        task automatic drive_sink_credit();
                logic [31:0] r;
                if (sink_run == 0) begin
                        r        = next_rand();
                        sink_on  = !sink_on;
                        // bursts up to 16, gaps up to 64 cycles
                        sink_run = sink_on ? int'(r[31:28]) + 1 : int'(r[31:26]) + 1;
                end
                sink_run   = sink_run - 1;
                out_credit = sink_on && ((granted - delivered) < sink_limit);
                if (out_credit) begin
                        granted = granted + 1;
                end
        endtask

        task automatic compare_value(input string name, input logic [data_width-1:0] expected,
                                     input logic [data_width-1:0] actual);
                assert (actual === expected) else begin
                        errors = errors + 1;
                        $display("ERROR %s expected %h actual %h at %0t",
                                 name, expected, actual, $time);
                end
        endtask

        ////////////////////////////////////////
        // output checker
        ////////////////////////////////////////

        always @(negedge clk) begin : check_outputs
                logic [data_width-1:0]          exp_res;
                logic [alu_pkg::flag_count-1:0] exp_flg;
                if (rst_n === 1'b1 && out_valid === 1'b1) begin
                        if (exp_result_q.size() == 0) begin
                                errors = errors + 1;
                                $display("out_valid rose with no request outstanding at %0t",
                                         $time);
                        end else begin
                                exp_res = exp_result_q.pop_front();
                                exp_flg = exp_flag_q.pop_front();
                                compare_value("out_result", exp_res, out_result);
                                compare_value("out_zero", data_width'(exp_flg[0]),
                                              data_width'(out_zero));
                                compare_value("out_cout", data_width'(exp_flg[1]),
                                              data_width'(out_cout));
                                compare_value("out_overflow", data_width'(exp_flg[2]),
                                              data_width'(out_overflow));
                                delivered = delivered + 1;
                        end
                end
        end

        always @(posedge clk) begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= timeout_cycles) begin
                        $display("timeout after %0d cycles with %0d of %0d results delivered",
                                 cycle_count, delivered, req_count);
                        $display("Done: errors found");
                        $finish;
                end
        end

        ////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////

        initial begin
                rst_n      = 1'b0;
                req_valid  = 1'b0;
                req_op     = alu_pkg::op_and;
                req_src1   = '0;
                req_src2   = '0;
                out_credit = 1'b0;
                repeat (3) @(posedge clk);      // 3 cycles of reset
                @(negedge clk);
                rst_n = 1'b1;
                while (issued < req_count || delivered < req_count) begin
                        @(negedge clk);
                        if (in_credit) begin
                                src_credits = src_credits + 1;
                        end
                        drive_sink_credit();
                        if (issued < req_count && src_credits > 0 &&
                            next_rand() < 32'hc000_0000) begin
                                issue_request();
                        end else begin
                                req_valid = 1'b0;
                        end
                end
                @(negedge clk);
                req_valid  = 1'b0;
                out_credit = 1'b0;
                // every departure handed its credit back
                compare_value("src_credits", data_width'(fifo_depth), data_width'(src_credits));
                errors = errors + u_alu_top.u_checks.fail_count;
                $display("checked %0d results, errors: %0d", delivered, errors);
                if (errors == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

// ==== verilog.f ====
hdl/alu_pkg.sv
hdl/alu_execute.sv
hdl/alu_result_fifo.sv
hdl/alu_output_stage.sv
hdl/alu_top.sv
testbench/alu_assertions.sv
testbench/alu_tb.sv
